// File: build.f
verilog/clkPkg.sv
verilog/rateDivider.sv
verilog/burstCounter.sv
verilog/diagConfigRegs.sv
verilog/diagReadMux.sv
verilog/clockGateCtl.sv
verilog/clkBoard.sv
verification/tbClockGen.sv
verification/clkBoard_sva.sv
verification/clkBoardTb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := clkBoardTb
FILELIST  := build.f
OBJDIR    := obj_dir
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIMBIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIMBIN)
	-./$(SIMBIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: verification/clkBoardTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CLK board testbench
// Drives the diagnostic bus and checks pulses and readback words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module clkBoardTb
  import clkPkg::*;
;

  logic CLK;
  logic FPGA_RESET;
  logic ctlFunc, loadFunc, diagRead;
  diagSel_t diagSel;
  ebusNibble_t ebusData;
  logic eboxClk, crmClk, edpClk, ctlClk, mrReset;
  diagWord_t readData;

  int cycleNo = 0;
  int prevCycle;
  bit havePrev;
  int eboxCount, crmCount, edpCount, ctlCount;
  int gaps[$];

  tbClockGen u_tbClockGen (.CLK(CLK), .FPGA_RESET(FPGA_RESET));

  clkBoard u_clkBoard (
    .CLK(CLK), .FPGA_RESET(FPGA_RESET), .ctlFunc(ctlFunc), .loadFunc(loadFunc),
    .diagSel(diagSel), .ebusData(ebusData), .diagRead(diagRead),
    .eboxClk(eboxClk), .crmClk(crmClk), .edpClk(edpClk), .ctlClk(ctlClk),
    .mrReset(mrReset), .readData(readData)
  );

  // Pulse monitor, sampled mid-cycle where outputs are settled
  always @(negedge CLK) begin
    cycleNo++;
    if (!FPGA_RESET && eboxClk) begin
      eboxCount++;
      if (havePrev) gaps.push_back(cycleNo - prevCycle);
      prevCycle = cycleNo;
      havePrev  = 1'b1;
    end
    if (!FPGA_RESET && crmClk) crmCount++;
    if (!FPGA_RESET && edpClk) edpCount++;
    if (!FPGA_RESET && ctlClk) ctlCount++;
  end

  // Expected readback word from the register and state rules
  function automatic diagWord_t refWord(diagSel_t sel, logic runF, logic burstF,
                                        logic stepF, rateSel_t rate, burstCount_t cnt,
                                        logic rst, logic [2:0] dis);
    case (sel)
      RD_BURST_HIGH: return cnt[7:2];
      RD_STATUS:     return {runF, burstF, rate, cnt[1:0]};
      RD_CONFIG:     return {rst, stepF, dis, 1'b0};
      default:       return '0;
    endcase
  endfunction

  function automatic int refSpacing(rateSel_t rate);
    return 1 << rate;
  endfunction

  task automatic failNow(string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "stopping on first error");
  endtask

  task automatic compareWord(string name, diagWord_t exp, diagWord_t act);
    if (exp !== act) failNow($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
  endtask

  task automatic compareCount(string name, burstCount_t exp, burstCount_t act);
    if (exp !== act) failNow($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic comparePulses(string name, int exp, int act);
    if (exp != act) failNow($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic compareLevel(string name, logic exp, logic act);
    if (exp !== act) failNow($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
  endtask

  task automatic nextCycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic ctlStrobe(diagSel_t code);
    diagSel = code;
    ctlFunc = 1'b1;
    nextCycle();
    ctlFunc = 1'b0;
  endtask

  task automatic loadStrobe(diagSel_t code, ebusNibble_t nib);
    diagSel  = code;
    ebusData = nib;
    loadFunc = 1'b1;
    nextCycle();
    loadFunc = 1'b0;
  endtask

  task automatic readback(diagSel_t sel, output diagWord_t w);
    diagSel  = sel;
    diagRead = 1'b1;
    #2 w     = readData;
    diagRead = 1'b0;
  endtask

  task automatic clearCounters();
    eboxCount = 0;
    crmCount  = 0;
    edpCount  = 0;
    ctlCount  = 0;
    havePrev  = 1'b0;
    gaps.delete();
  endtask

  // Polls one readback bit until it drops
  task automatic waitBitClear(diagSel_t sel, int bitNo, int limit, string what);
    diagWord_t w;
    bit done;
    done = 1'b0;
    for (int i = 0; i < limit && !done; i++) begin
      readback(sel, w);
      if (!w[bitNo]) done = 1'b1;
      else nextCycle();
    end
    if (!done) failNow($sformatf("Timed out waiting for %s to finish", what));
  endtask

  task automatic waitPulses(int target, int limit);
    for (int i = 0; i < limit && eboxCount < target; i++) nextCycle();
    if (eboxCount < target) failNow("Timed out waiting for eboxClk pulses in RUN");
  endtask

  // Stops the clock and checks that no more pulses arrive
  task automatic stopAndCheck(diagSel_t code, string name);
    int held;
    ctlStrobe(code);
    repeat (2) nextCycle();
    held = eboxCount;
    repeat (16) nextCycle();
    comparePulses(name, held, eboxCount);
  endtask

  initial begin
    diagWord_t w;
    diagWord_t hi;
    burstCount_t cnt;
    burstCount_t got;
    rateSel_t rate;
    logic [2:0] dis;
    ctlFunc  = 1'b0;
    loadFunc = 1'b0;
    diagRead = 1'b0;
    diagSel  = '0;
    ebusData = '0;
    void'($urandom(32'hd4cc));
    for (int i = 0; i < 20 && FPGA_RESET !== 1'b0; i++) @(posedge CLK);
    if (FPGA_RESET !== 1'b0) failNow("Reset never released");
    nextCycle();
    clearCounters();

    // After reset
    for (int s = 0; s < 3; s++) begin
      readback(diagSel_t'(s), w);
      compareWord($sformatf("reset word %0d", s), '0, w);
    end
    repeat (10) nextCycle();
    comparePulses("reset pulses", 0, eboxCount);

    // Random bursts
    for (int t = 0; t < 6; t++) begin
      cnt  = burstCount_t'($urandom);
      rate = rateSel_t'($urandom);
      loadStrobe(LD_BURST_LSB, cnt[3:0]);
      loadStrobe(LD_BURST_MSB, cnt[7:4]);
      loadStrobe(LD_RATE_SEL, {2'b00, rate});
      readback(RD_BURST_HIGH, hi);
      readback(RD_STATUS, w);
      got = {hi, w[1:0]};
      compareCount("loaded count", cnt, got);
      clearCounters();
      ctlStrobe(CTL_BURST);
      readback(RD_STATUS, w);
      compareWord("status in burst", refWord(RD_STATUS, 0, 1, 0, rate, cnt, 0, 0), w);
      waitBitClear(RD_STATUS, 4, 8 * 256 + 20, "burst");
      repeat (2) nextCycle();
      comparePulses("burst pulses", int'(cnt), eboxCount);
      readback(RD_BURST_HIGH, w);
      compareWord("burst high after", refWord(RD_BURST_HIGH, 0, 0, 0, rate, 0, 0, 0), w);
      readback(RD_STATUS, w);
      compareWord("status after", refWord(RD_STATUS, 0, 0, 0, rate, 0, 0, 0), w);
    end

    // Single step and empty burst
    clearCounters();
    ctlStrobe(CTL_SINGLE_STEP);
    readback(RD_CONFIG, w);
    compareWord("config in step", refWord(RD_CONFIG, 0, 0, 1, 0, 0, 0, 0), w);
    waitBitClear(RD_CONFIG, 4, 20, "single step");
    repeat (4) nextCycle();
    comparePulses("step pulses", 1, eboxCount);
    loadStrobe(LD_BURST_LSB, 4'h0);
    loadStrobe(LD_BURST_MSB, 4'h0);
    clearCounters();
    ctlStrobe(CTL_BURST);
    waitBitClear(RD_STATUS, 4, 20, "empty burst");
    repeat (10) nextCycle();
    comparePulses("empty burst pulses", 0, eboxCount);

    // RUN spacing at each rate
    for (int r = 0; r < 4; r++) begin
      loadStrobe(LD_RATE_SEL, ebusNibble_t'(r));
      clearCounters();
      ctlStrobe(CTL_START);
      readback(RD_STATUS, w);
      compareWord("status in run", refWord(RD_STATUS, 1, 0, 0, rateSel_t'(r), 0, 0, 0), w);
      waitPulses(6, 80);
      foreach (gaps[g]) comparePulses($sformatf("rate %0d spacing", r),
                                      refSpacing(rateSel_t'(r)), gaps[g]);
      stopAndCheck(3'd0, "pulses after stop");
    end

    // Section clock disables
    loadStrobe(LD_RATE_SEL, 4'h0);
    for (int t = 0; t < 6; t++) begin
      dis = 3'($urandom);
      loadStrobe(LD_EBOX_DIS, {1'b0, dis});
      readback(RD_CONFIG, w);
      compareWord("config disables", refWord(RD_CONFIG, 0, 0, 0, 0, 0, 0, dis), w);
      clearCounters();
      ctlStrobe(CTL_START);
      waitPulses(10, 40);
      stopAndCheck(3'd4, "pulses after stop");
      comparePulses("crm clocks", dis[2] ? 0 : eboxCount, crmCount);
      comparePulses("edp clocks", dis[1] ? 0 : eboxCount, edpCount);
      comparePulses("ctl clocks", dis[0] ? 0 : eboxCount, ctlCount);
    end
    loadStrobe(LD_EBOX_DIS, 4'h0);

    // Set and clear reset, each stops a running clock
    clearCounters();
    ctlStrobe(CTL_START);
    waitPulses(3, 40);
    stopAndCheck(CTL_SET_RESET, "pulses after set reset");
    compareLevel("mrReset after set reset", 1'b1, mrReset);
    readback(RD_CONFIG, w);
    compareWord("config set reset", refWord(RD_CONFIG, 0, 0, 0, 0, 0, 1, 0), w);
    readback(RD_STATUS, w);
    compareWord("status set reset", refWord(RD_STATUS, 0, 0, 0, 0, 0, 1, 0), w);
    ctlStrobe(CTL_START);
    waitPulses(eboxCount + 3, 40);
    stopAndCheck(CTL_CLR_RESET, "pulses after clear reset");
    readback(RD_CONFIG, w);
    compareWord("config clear reset", refWord(RD_CONFIG, 0, 0, 0, 0, 0, 0, 0), w);
    compareLevel("mrReset after clear reset", 1'b0, mrReset);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: verification/clkBoard_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock gate control assertions
// Section clock, burst decrement and idle checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module clkBoardSva
  import clkPkg::*;
(
  input logic      CLK,
  input logic      FPGA_RESET,
  input logic      ctlFunc,
  input logic      burstDec,
  input logic      eboxClk,
  input logic      crmClk,
  input logic      edpClk,
  input logic      ctlClk,
  input clkState_e clkState
);

  sectionNeedsEbox: assert property (@(posedge CLK) disable iff (FPGA_RESET)
    (crmClk | edpClk | ctlClk) |-> eboxClk)
    else $error("section clock high without eboxClk");

  decOnlyInBurst: assert property (@(posedge CLK) disable iff (FPGA_RESET)
    burstDec |-> clkState == BURST)
    else $error("burstDec outside BURST");

  // Idle stays quiet unless a control strobe arrives
  idleNoPulse: assert property (@(posedge CLK) disable iff (FPGA_RESET)
    (clkState == IDLE && !ctlFunc) |=> !eboxClk)
    else $error("eboxClk pulse after idle cycle");

endmodule

bind clockGateCtl clkBoardSva u_clkBoardSva (
  .CLK(CLK), .FPGA_RESET(FPGA_RESET), .ctlFunc(ctlFunc), .burstDec(burstDec),
  .eboxClk(eboxClk), .crmClk(crmClk), .edpClk(edpClk), .ctlClk(ctlClk),
  .clkState(clkState)
);

// File: verification/tbClockGen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset
// 20 ns clock, reset held for two cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tbClockGen (
  output logic CLK,
  output logic FPGA_RESET
);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  initial begin
    FPGA_RESET = 1'b1;
    repeat (2) @(posedge CLK);
    #1 FPGA_RESET = 1'b0;
  end

endmodule

// File: verilog/clkBoard.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CLK board top level
// Diagnostic bus control of the gated EBOX clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module clkBoard
  import clkPkg::*;
(
  input  logic        CLK,
  input  logic        FPGA_RESET,
  input  logic        ctlFunc,
  input  logic        loadFunc,
  input  diagSel_t    diagSel,
  input  ebusNibble_t ebusData,
  input  logic        diagRead,
  output logic        eboxClk,
  output logic        crmClk,
  output logic        edpClk,
  output logic        ctlClk,
  output logic        mrReset,
  output diagWord_t   readData
);

  rateSel_t    rateSel;
  logic        crmDis;
  logic        edpDis;
  logic        ctlDis;
  logic        rateTick;
  burstCount_t burstCount;
  logic        burstZero;
  logic        burstDec;
  clkState_e   clkState;

  clockGateCtl u_clockGateCtl (
    .CLK(CLK), .FPGA_RESET(FPGA_RESET), .ctlFunc(ctlFunc), .diagSel(diagSel),
    .rateTick(rateTick), .burstZero(burstZero),
    .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis),
    .burstDec(burstDec), .eboxClk(eboxClk), .crmClk(crmClk), .edpClk(edpClk),
    .ctlClk(ctlClk), .mrReset(mrReset), .clkState(clkState)
  );

  rateDivider u_rateDivider (
    .CLK(CLK), .FPGA_RESET(FPGA_RESET), .rateSel(rateSel), .rateTick(rateTick)
  );

  burstCounter u_burstCounter (
    .CLK(CLK), .FPGA_RESET(FPGA_RESET), .loadFunc(loadFunc), .diagSel(diagSel),
    .ebusData(ebusData), .burstDec(burstDec),
    .burstCount(burstCount), .burstZero(burstZero)
  );

  diagConfigRegs u_diagConfigRegs (
    .CLK(CLK), .FPGA_RESET(FPGA_RESET), .loadFunc(loadFunc), .diagSel(diagSel),
    .ebusData(ebusData), .rateSel(rateSel),
    .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis)
  );

  diagReadMux u_diagReadMux (
    .diagRead(diagRead), .diagSel(diagSel), .burstCount(burstCount),
    .clkState(clkState), .mrReset(mrReset), .rateSel(rateSel),
    .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis), .readData(readData)
  );

endmodule

// File: verilog/clockGateCtl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock gate control
// Control function decode, run/step/burst FSM, EBOX and section clock pulses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module clockGateCtl
  import clkPkg::*;
(
  input  logic      CLK,
  input  logic      FPGA_RESET,
  input  logic      ctlFunc,
  input  diagSel_t  diagSel,
  input  logic      rateTick,
  input  logic      burstZero,
  input  logic      crmDis,
  input  logic      edpDis,
  input  logic      ctlDis,
  output logic      burstDec,
  output logic      eboxClk,
  output logic      crmClk,
  output logic      edpClk,
  output logic      ctlClk,
  output logic      mrReset,
  output clkState_e clkState
);

  clkState_e nextState;
  logic      pulseReq;

  // One pulse opportunity per rate tick while not idle
  always_comb begin
    case (clkState)
      RUN:     pulseReq = rateTick;
      STEP:    pulseReq = rateTick;
      BURST:   pulseReq = rateTick & ~burstZero;   // Empty burst gives nothing
      default: pulseReq = 1'b0;
    endcase
  end

  assign burstDec = (clkState == BURST) & pulseReq;

  always_comb begin
    nextState = clkState;
    if (ctlFunc) begin
      case (diagSel)
        CTL_START:       nextState = RUN;
        CTL_SINGLE_STEP: nextState = STEP;
        CTL_BURST:       nextState = BURST;
        default:         nextState = IDLE;   // Stop, and both reset codes
      endcase
    end else begin
      case (clkState)
        STEP: begin
          if (rateTick) begin
            nextState = IDLE;   // Single pulse taken
          end
        end
        BURST: begin
          if (burstZero) begin
            nextState = IDLE;
          end
        end
        default: nextState = clkState;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      clkState <= IDLE;
      eboxClk  <= 1'b0;
      mrReset  <= 1'b0;
    end else begin
      clkState <= nextState;
      eboxClk  <= pulseReq;
      if (ctlFunc && diagSel == CTL_SET_RESET) begin
        mrReset <= 1'b1;
      end else if (ctlFunc && diagSel == CTL_CLR_RESET) begin
        mrReset <= 1'b0;
      end
    end
  end

  // Section clocks follow eboxClk unless disabled
  assign {crmClk, edpClk, ctlClk} = {3{eboxClk}} & ~{crmDis, edpDis, ctlDis};

endmodule

// File: verilog/diagReadMux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Diagnostic readback mux
// Selects the status word, zero when no read is under way
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module diagReadMux
  import clkPkg::*;
(
  input  logic        diagRead,
  input  diagSel_t    diagSel,
  input  burstCount_t burstCount,
  input  clkState_e   clkState,
  input  logic        mrReset,
  input  rateSel_t    rateSel,
  input  logic        crmDis,
  input  logic        edpDis,
  input  logic        ctlDis,
  output diagWord_t   readData
);

  always_comb begin
    readData = '0;
    if (diagRead) begin
      case (diagSel)
        RD_BURST_HIGH: readData = burstCount[7:2];
        RD_STATUS: begin
          readData = {clkState == RUN, clkState == BURST, rateSel, burstCount[1:0]};
        end
        RD_CONFIG: begin
          // Low bit unused
          readData = {mrReset, clkState == STEP, crmDis, edpDis, ctlDis, 1'b0};
        end
        default: readData = '0;
      endcase
    end
  end

endmodule

// File: verilog/diagConfigRegs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Diagnostic config registers
// Rate select and EBOX section clock disables
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module diagConfigRegs
  import clkPkg::*;
(
  input  logic        CLK,
  input  logic        FPGA_RESET,
  input  logic        loadFunc,
  input  diagSel_t    diagSel,
  input  ebusNibble_t ebusData,
  output rateSel_t    rateSel,
  output logic        crmDis,
  output logic        edpDis,
  output logic        ctlDis
);

  logic loadRate;
  logic loadDis;

  assign loadRate = loadFunc && (diagSel == LD_RATE_SEL);
  assign loadDis  = loadFunc && (diagSel == LD_EBOX_DIS);

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      rateSel <= '0;
      crmDis  <= 1'b0;
      edpDis  <= 1'b0;
      ctlDis  <= 1'b0;
    end else begin
      if (loadRate) rateSel <= ebusData[1:0];   // Bus bits 34..35
      if (loadDis) begin
        {crmDis, edpDis, ctlDis} <= ebusData[2:0];
      end
    end
  end

endmodule

// File: verilog/burstCounter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Burst counter
// 8-bit count loaded by nibbles, counts down once per burst pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module burstCounter
  import clkPkg::*;
(
  input  logic        CLK,
  input  logic        FPGA_RESET,
  input  logic        loadFunc,
  input  diagSel_t    diagSel,
  input  ebusNibble_t ebusData,
  input  logic        burstDec,
  output burstCount_t burstCount,
  output logic        burstZero
);

  logic loadLsb;
  logic loadMsb;

  assign loadLsb = loadFunc && (diagSel == LD_BURST_LSB);
  assign loadMsb = loadFunc && (diagSel == LD_BURST_MSB);

  assign burstZero = (burstCount == '0);

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      burstCount <= '0;
    end else if (loadLsb) begin
      burstCount[3:0] <= ebusData;
    end else if (loadMsb) begin
      burstCount[7:4] <= ebusData;
    end else if (burstDec && !burstZero) begin
      // Holds at zero
      burstCount <= burstCount - 1'b1;
    end
  end

endmodule

// File: verilog/rateDivider.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rate divider
// Free-running count giving one clock opportunity per 1, 2, 4 or 8 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rateDivider
  import clkPkg::*;
(
  input  logic     CLK,
  input  logic     FPGA_RESET,
  input  rateSel_t rateSel,
  output logic     rateTick
);

  logic [RATE_CNT_W-1:0] divCount;
  logic [RATE_CNT_W-1:0] tickMask;

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      divCount <= '0;
    end else begin
      divCount <= divCount + 1'b1;   // Never stops, phase is free
    end
  end

  // Low rateSel bits of the count, all ones for code 3 after the wrap
  assign tickMask = RATE_CNT_W'(3'b001 << rateSel) - 1'b1;

  assign rateTick = (divCount & tickMask) == '0;

endmodule

// File: verilog/clkPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CLK board shared definitions
// Function codes, field widths and the clock control states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package clkPkg;

  localparam int DIAG_SEL_W   = 3;   // Bus bits 4..6
  localparam int NIBBLE_W     = 4;   // Bus bits 32..35, bit 3 is bus bit 32
  localparam int DIAG_WORD_W  = 6;
  localparam int BURST_CNT_W  = 8;
  localparam int RATE_SEL_W   = 2;
  localparam int RATE_CNT_W   = 3;   // Divides by up to 8

  typedef logic [DIAG_SEL_W-1:0]  diagSel_t;
  typedef logic [NIBBLE_W-1:0]    ebusNibble_t;
  typedef logic [DIAG_WORD_W-1:0] diagWord_t;
  typedef logic [BURST_CNT_W-1:0] burstCount_t;
  typedef logic [RATE_SEL_W-1:0]  rateSel_t;

  typedef enum logic [1:0] {IDLE, RUN, STEP, BURST} clkState_e;

  // Control functions, anything else is a stop
  localparam diagSel_t CTL_START       = 3'd1;
  localparam diagSel_t CTL_SINGLE_STEP = 3'd2;
  localparam diagSel_t CTL_BURST       = 3'd5;
  localparam diagSel_t CTL_CLR_RESET   = 3'd6;
  localparam diagSel_t CTL_SET_RESET   = 3'd7;

  // Load functions
  localparam diagSel_t LD_BURST_LSB = 3'd2;
  localparam diagSel_t LD_BURST_MSB = 3'd3;
  localparam diagSel_t LD_RATE_SEL  = 3'd4;
  localparam diagSel_t LD_EBOX_DIS  = 3'd5;

  // Readback selects
  localparam diagSel_t RD_BURST_HIGH = 3'd0;
  localparam diagSel_t RD_STATUS     = 3'd1;
  localparam diagSel_t RD_CONFIG     = 3'd2;

endpackage
